/* hdl/pow_pkg.sv */
// Shared types, SHA-256 round constants, initial hash value
// and the word byte-swap function
package pow_pkg;

	// Byte address into the 112-byte header store
	typedef logic [6:0] store_addr_t;

	// Eight chaining words, h[0] is word a
	typedef struct packed {
		logic [0:7][31:0] h;
	} hash_state_t;

	// One 512-bit message block, w[0] is the first word on the wire
	typedef struct packed {
		logic [0:15][31:0] w;
	} sha_block_t;

	// Header as big-endian message words
	// First block is bytes 0..63, tail is bytes 64..79
	typedef struct packed {
		logic [0:15][31:0] head;
		logic [0:3][31:0] tail;
	} header_msg_t;

	// Round constants, index 0 first
	localparam logic [0:63][31:0] sha_k = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial chaining state
	localparam hash_state_t sha_h0 = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Reverse the four bytes of a word
	// Turns a little-endian byte group into a big-endian word and back
	function automatic logic [31:0] swap_bytes32(input logic [31:0] word);
		return {word[7:0], word[15:8], word[23:16], word[31:24]};
	endfunction

endpackage

/* hdl/header_store.sv */
// Byte-addressed header and target store with nonce increment
// and word-flipped message and target views
`timescale 1ns/1ns

module header_store (
	input  logic                 clk,
	input  logic                 data_en,
	input  pow_pkg::store_addr_t data_sel,
	input  logic [7:0]           data,
	input  logic                 write_lock,
	input  logic                 nonce_inc,
	output pow_pkg::header_msg_t msg,
	output logic [255:0]         target,
	output logic [31:0]          nonce
);
	import pow_pkg::*;

	// Address map
	localparam int NONCE_LO = 76;
	localparam int STORE_BYTES = 112;

	// Byte 0 sits in the low slot
	logic [STORE_BYTES-1:0][7:0] store;
	logic                        wr_ok;

	// Host writes only land while the engine is idle
	// Addresses past the target are dropped
	assign wr_ok = data_en && !write_lock && (data_sel < 7'(STORE_BYTES));

	always_ff @(posedge clk) begin
		if (nonce_inc) begin
			// Bytes 76..79 read as one little-endian word, so a plain add carries upward
			store[NONCE_LO+3:NONCE_LO] <= store[NONCE_LO+3:NONCE_LO] + 32'd1;
		end else if (wr_ok) begin
			store[data_sel] <= data;
		end
	end

	// Message words
	// Each group of four bytes becomes one big-endian word, lowest address on top
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			msg.head[i] = swap_bytes32(store[4*i +: 4]);
		end
		// Header tail holds bytes 64..79, nonce included
		for (int i = 0; i < 4; i++) begin
			msg.tail[i] = swap_bytes32(store[64 + 4*i +: 4]);
		end
	end

	// Target as a number, byte 80 least significant
	assign target = store[111:80];

	// Current nonce, little-endian
	assign nonce = store[NONCE_LO+3:NONCE_LO];

endmodule

/* hdl/sha256_compress.sv */
// Iterative SHA-256 compression, one round per clock
// Load cycle, 64 rounds, then the final add onto the saved state
`timescale 1ns/1ns

module sha256_compress (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 blk_start,
	input  pow_pkg::sha_block_t  blk,
	input  pow_pkg::hash_state_t state_in,
	output logic                 blk_done,
	output pow_pkg::hash_state_t state_out
);
	import pow_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ROUND,
		ST_ADD
	} cmp_state_t;

	cmp_state_t  st;
	logic [5:0]  round;
	// Chaining value the block started from
	hash_state_t base;
	// Working variables a..h
	hash_state_t work;
	hash_state_t work_next;
	// Sliding schedule window, w[0] is W_t of the current round
	sha_block_t  sched;
	logic [31:0] w_next;
	logic [31:0] t1;
	logic [31:0] t2;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic logic [31:0] big_sig0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] big_sig1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [31:0] small_sig0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] small_sig1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// One round of the compression function
	always_comb begin
		// Ch on e,f,g and Maj on a,b,c
		t1 = work.h[7] + big_sig1(work.h[4])
			+ ((work.h[4] & work.h[5]) ^ (~work.h[4] & work.h[6]))
			+ sha_k[round] + sched.w[0];
		t2 = big_sig0(work.h[0])
			+ ((work.h[0] & work.h[1]) ^ (work.h[0] & work.h[2]) ^ (work.h[1] & work.h[2]));
		work_next.h[0] = t1 + t2;
		work_next.h[1] = work.h[0];
		work_next.h[2] = work.h[1];
		work_next.h[3] = work.h[2];
		work_next.h[4] = work.h[3] + t1;
		work_next.h[5] = work.h[4];
		work_next.h[6] = work.h[5];
		work_next.h[7] = work.h[6];
		// W_{t+16} from the window
		w_next = small_sig1(sched.w[14]) + sched.w[9] + small_sig0(sched.w[1]) + sched.w[0];
	end

	// Sequencing
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st       <= ST_IDLE;
			round    <= '0;
			blk_done <= 1'b0;
		end else begin
			blk_done <= 1'b0;
			case (st)
				ST_IDLE: begin
					if (blk_start) begin
						st    <= ST_ROUND;
						round <= '0;
					end
				end
				ST_ROUND: begin
					round <= round + 6'd1;
					// Last round just ran
					if (round == 6'd63) begin
						st <= ST_ADD;
					end
				end
				ST_ADD: begin
					blk_done <= 1'b1;
					st       <= ST_IDLE;
				end
				default: st <= ST_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk) begin
		case (st)
			ST_IDLE: begin
				if (blk_start) begin
					base  <= state_in;
					work  <= state_in;
					sched <= blk;
				end
			end
			ST_ROUND: begin
				work    <= work_next;
				// Oldest word drops out, new one enters at the far end
				sched.w <= {sched.w[1:15], w_next};
			end
			ST_ADD: begin
				for (int i = 0; i < 8; i++) begin
					state_out.h[i] <= base.h[i] + work.h[i];
				end
			end
			default: ;
		endcase
	end

endmodule

/* hdl/double_hash_seq.sv */
// Double SHA-256 sequencer over the 80-byte header
// Builds the three padded blocks and holds the final digest
`timescale 1ns/1ns

module double_hash_seq (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 hash_start,
	input  pow_pkg::header_msg_t msg,
	output logic                 hash_valid,
	output pow_pkg::hash_state_t digest
);
	import pow_pkg::*;

	typedef enum logic [1:0] {
		SQ_IDLE,
		SQ_BLK1,
		SQ_BLK2,
		SQ_BLK3
	} seq_state_t;

	seq_state_t  st;
	// First block launch, one cycle after hash_start
	logic        kick;
	logic        blk_start;
	logic        blk_done;
	sha_block_t  blk;
	sha_block_t  blk_two;
	sha_block_t  blk_three;
	hash_state_t state_in;
	hash_state_t state_out;

	// Header tail, 0x80 marker, zeros, bit length 640
	assign blk_two = {msg.tail, 32'h8000_0000, 320'd0, 32'd640};

	// First digest, 0x80 marker, zeros, bit length 256
	assign blk_three = {state_out.h, 32'h8000_0000, 192'd0, 32'd256};

	// Next block is launched straight off blk_done, no gap
	assign blk_start = kick || (blk_done && (st == SQ_BLK1 || st == SQ_BLK2));

	// Block and chaining input for the next launch
	always_comb begin
		if (kick) begin
			blk      = msg.head;
			state_in = sha_h0;
		end else if (st == SQ_BLK1) begin
			// Second block chains on the first
			blk      = blk_two;
			state_in = state_out;
		end else begin
			// Outer hash restarts from the initial state
			blk      = blk_three;
			state_in = sha_h0;
		end
	end

	sha256_compress sha256_compress_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.blk_start (blk_start),
		.blk       (blk),
		.state_in  (state_in),
		.blk_done  (blk_done),
		.state_out (state_out)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st         <= SQ_IDLE;
			kick       <= 1'b0;
			hash_valid <= 1'b0;
		end else begin
			kick       <= 1'b0;
			hash_valid <= 1'b0;
			case (st)
				SQ_IDLE: begin
					if (hash_start) begin
						st   <= SQ_BLK1;
						kick <= 1'b1;
					end
				end
				SQ_BLK1: if (blk_done) st <= SQ_BLK2;
				SQ_BLK2: if (blk_done) st <= SQ_BLK3;
				SQ_BLK3: begin
					if (blk_done) begin
						hash_valid <= 1'b1;
						st         <= SQ_IDLE;
					end
				end
				default: st <= SQ_IDLE;
			endcase
		end
	end

	// Digest words kept byte-reversed
	// Each word then reads as a little-endian slice of the hash number
	always_ff @(posedge clk) begin
		if (st == SQ_BLK3 && blk_done) begin
			for (int i = 0; i < 8; i++) begin
				digest.h[i] <= swap_bytes32(state_out.h[i]);
			end
		end
	end

endmodule

/* hdl/nonce_search.sv */
// Nonce search control, target compare, attempt counter
`timescale 1ns/1ns

module nonce_search #(
	parameter int ATTEMPT_WIDTH = 16
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     start,
	input  logic [ATTEMPT_WIDTH-1:0] attempts,
	input  pow_pkg::hash_state_t     digest,
	input  logic                     hash_valid,
	input  logic [255:0]             target,
	output logic                     hash_start,
	output logic                     nonce_inc,
	output logic                     busy,
	output logic                     done,
	output logic                     found,
	output logic [255:0]             hash_value
);

	typedef enum logic [2:0] {
		SR_IDLE,
		SR_HASH,
		SR_CMP,
		SR_STEP,
		SR_END
	} search_state_t;

	search_state_t            st;
	// Attempts left, current one included
	logic [ATTEMPT_WIDTH-1:0] remaining;
	logic [255:0]             digest_le;
	// Hash not above target
	logic                     hit;

	// Digest words arrive byte-reversed
	// Word 0 holds digest bytes 0..3, so it is the low slice
	always_comb begin
		for (int j = 0; j < 8; j++) begin
			digest_le[32*j +: 32] = digest.h[j];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			st         <= SR_IDLE;
			remaining  <= '0;
			hit        <= 1'b0;
			hash_start <= 1'b0;
			nonce_inc  <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			found      <= 1'b0;
		end else begin
			hash_start <= 1'b0;
			nonce_inc  <= 1'b0;
			done       <= 1'b0;
			case (st)
				SR_IDLE: begin
					// Start is only seen here, so a start while busy drops out
					if (start) begin
						busy      <= 1'b1;
						found     <= 1'b0;
						remaining <= attempts;
						if (attempts == '0) begin
							st <= SR_END;
						end else begin
							hash_start <= 1'b1;
							st         <= SR_HASH;
						end
					end
				end
				SR_HASH: begin
					if (hash_valid) begin
						hit <= (digest_le <= target);
						st  <= SR_CMP;
					end
				end
				SR_CMP: begin
					if (hit) begin
						found <= 1'b1;
						done  <= 1'b1;
						busy  <= 1'b0;
						st    <= SR_IDLE;
					end else begin
						// Every miss steps the nonce, the last one too
						nonce_inc <= 1'b1;
						if (remaining == ATTEMPT_WIDTH'(1)) begin
							// done follows once the store holds the stepped nonce
							st <= SR_END;
						end else begin
							remaining <= remaining - ATTEMPT_WIDTH'(1);
							st        <= SR_STEP;
						end
					end
				end
				// Store has the new nonce by now
				SR_STEP: begin
					hash_start <= 1'b1;
					st         <= SR_HASH;
				end
				// Attempts used up, or zero attempts without hashing
				SR_END: begin
					done <= 1'b1;
					busy <= 1'b0;
					st   <= SR_IDLE;
				end
				default: st <= SR_IDLE;
			endcase
		end
	end

	// Last hash as a number, kept for the host
	always_ff @(posedge clk) begin
		if (st == SR_HASH && hash_valid) begin
			hash_value <= digest_le;
		end
	end

endmodule

/* hdl/pow_miner_top.sv */
// Proof-of-work miner top level
// Header store, double-hash sequencer and nonce search
`timescale 1ns/1ns

module pow_miner_top #(
	parameter int ATTEMPT_WIDTH = 16
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     data_en,
	input  pow_pkg::store_addr_t     data_sel,
	input  logic [7:0]               data,
	input  logic                     start,
	input  logic [ATTEMPT_WIDTH-1:0] attempts,
	output logic                     busy,
	output logic                     done,
	output logic                     found,
	output logic [31:0]              nonce,
	output logic [255:0]             hash_value
);
	import pow_pkg::*;

	header_msg_t  msg;
	logic [255:0] target;
	hash_state_t  digest;
	logic         hash_start;
	logic         hash_valid;
	logic         nonce_inc;

	// Host writes locked out for the whole search
	header_store header_store_i (
		.clk        (clk),
		.data_en    (data_en),
		.data_sel   (data_sel),
		.data       (data),
		.write_lock (busy),
		.nonce_inc  (nonce_inc),
		.msg        (msg),
		.target     (target),
		.nonce      (nonce)
	);

	double_hash_seq double_hash_seq_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.hash_start (hash_start),
		.msg        (msg),
		.hash_valid (hash_valid),
		.digest     (digest)
	);

	nonce_search #(
		.ATTEMPT_WIDTH (ATTEMPT_WIDTH)
	) nonce_search_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.attempts   (attempts),
		.digest     (digest),
		.hash_valid (hash_valid),
		.target     (target),
		.hash_start (hash_start),
		.nonce_inc  (nonce_inc),
		.busy       (busy),
		.done       (done),
		.found      (found),
		.hash_value (hash_value)
	);

endmodule

/* testbench/tb_clock.sv */
// Testbench clock and reset generator
// 10 ns clock, active-low reset held for a few cycles
`timescale 1ns/1ns

module tb_clock #(
	parameter int HALF_PERIOD  = 5,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Release just after a rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 arst_n = 1'b1;
	end

endmodule

/* testbench/pow_miner_tb.sv */
// Miner testbench with genesis-header vectors
// Concurrent assertions check the outcome of every search
`timescale 1ns/1ns

module pow_miner_tb;
	import pow_pkg::*;

	localparam int ATTEMPT_WIDTH = 16;
	localparam int DONE_LIMIT    = 3000;
	localparam int BUSY_LIMIT    = 20;
	localparam int RESET_LIMIT   = 20;

	// Genesis header in serialized byte order, byte 0 on top
	localparam logic [639:0] GENESIS_HDR = {
		32'h01000000,
		256'h0,
		256'h3ba3edfd7a7b12b27ac72c3e67768f617fc81bc3888a51323a9fb8aa4b1e5e4a,
		32'h29ab5f49,
		32'hffff001d,
		32'h1dac2b7c
	};
	// Displayed genesis hash, as a number
	localparam logic [255:0] GENESIS_HASH =
		256'h000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f;

	logic                     clk;
	logic                     arst_n;
	logic                     data_en;
	store_addr_t              data_sel;
	logic [7:0]               data;
	logic                     start;
	logic [ATTEMPT_WIDTH-1:0] attempts;
	logic                     busy;
	logic                     done;
	logic                     found;
	logic [31:0]              nonce;
	logic [255:0]             hash_value;

	// Expected outcome of the running search
	logic                     check_armed;
	logic                     hash_check;
	logic                     idle_check;
	logic                     exp_found;
	logic [31:0]              exp_nonce;
	logic [255:0]             exp_hash;

	tb_clock #(
		.HALF_PERIOD  (5),
		.RESET_CYCLES (2)
	) tb_clock_i (
		.clk    (clk),
		.arst_n (arst_n)
	);

	pow_miner_top #(
		.ATTEMPT_WIDTH (ATTEMPT_WIDTH)
	) pow_miner_top_i (
		.clk        (clk),
		.arst_n     (arst_n),
		.data_en    (data_en),
		.data_sel   (data_sel),
		.data       (data),
		.start      (start),
		.attempts   (attempts),
		.busy       (busy),
		.done       (done),
		.found      (found),
		.nonce      (nonce),
		.hash_value (hash_value)
	);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [255:0] got,
			input logic [255:0] expected);
		abort_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// Idle outputs right after reset
	a_idle_busy: assert property (@(posedge clk) idle_check |-> !busy)
		else report_mismatch("busy", 256'($sampled(busy)), 256'(0));
	a_idle_done: assert property (@(posedge clk) idle_check |-> !done)
		else report_mismatch("done", 256'($sampled(done)), 256'(0));
	a_idle_found: assert property (@(posedge clk) idle_check |-> !found)
		else report_mismatch("found", 256'($sampled(found)), 256'(0));

	// Search outcome, taken in the done cycle
	a_found: assert property (@(posedge clk) disable iff (!arst_n)
		(done && check_armed) |-> (found == exp_found))
		else report_mismatch("found", 256'($sampled(found)), 256'(exp_found));
	a_nonce: assert property (@(posedge clk) disable iff (!arst_n)
		(done && check_armed) |-> (nonce == exp_nonce))
		else report_mismatch("nonce", 256'($sampled(nonce)), 256'(exp_nonce));
	a_hash: assert property (@(posedge clk) disable iff (!arst_n)
		(done && check_armed && hash_check) |-> (hash_value == exp_hash))
		else report_mismatch("hash_value", $sampled(hash_value), exp_hash);

	// done and found only ever end a busy period
	a_done_busy: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(done) |-> $past(busy))
		else abort_run("done pulsed although busy had not been high");
	a_found_busy: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(found) |-> $past(busy))
		else abort_run("found rose although busy had not been high");

	// Drive point, 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// Leaves data_en high so that writes can run back to back
	task automatic write_byte(input int addr, input logic [7:0] value);
		data_en  = 1'b1;
		data_sel = store_addr_t'(addr);
		data     = value;
		next_cycle();
	endtask

	task automatic write_nonce(input logic [31:0] value);
		for (int k = 0; k < 4; k++) begin
			write_byte(76 + k, value[8*k +: 8]);
		end
		data_en = 1'b0;
	endtask

	task automatic write_target(input logic [255:0] value);
		for (int k = 0; k < 32; k++) begin
			write_byte(80 + k, value[8*k +: 8]);
		end
		data_en = 1'b0;
	endtask

	// Whole store in shuffled address order
	task automatic load_store(input logic [31:0] nonce_val, input logic [255:0] target_val);
		logic [7:0] image [112];
		int         order [112];
		int         j;
		int         t;
		for (int i = 0; i < 80; i++) begin
			image[i] = GENESIS_HDR[639 - 8*i -: 8];
		end
		// Nonce little-endian in bytes 76..79
		for (int k = 0; k < 4; k++) begin
			image[76 + k] = nonce_val[8*k +: 8];
		end
		// Target with byte 80 least significant
		for (int k = 0; k < 32; k++) begin
			image[80 + k] = target_val[8*k +: 8];
		end
		for (int k = 0; k < 112; k++) begin
			order[k] = k;
		end
		// Fisher-Yates shuffle
		for (int k = 111; k > 0; k--) begin
			j        = int'($urandom_range(32'(k), 0));
			t        = order[k];
			order[k] = order[j];
			order[j] = t;
		end
		for (int k = 0; k < 112; k++) begin
			write_byte(order[k], image[order[k]]);
		end
		data_en = 1'b0;
	endtask

	task automatic pulse_start(input int count);
		start    = 1'b1;
		attempts = ATTEMPT_WIDTH'(count);
		next_cycle();
		start    = 1'b0;
	endtask

	task automatic wait_reset_release();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < RESET_LIMIT && !seen; n++) begin
			@(negedge clk);
			seen = arst_n;
		end
		if (!seen) abort_run("timeout: reset was never released");
	endtask

	// Sampled on the falling edge, where outputs are settled
	task automatic wait_busy();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < BUSY_LIMIT && !seen; n++) begin
			@(negedge clk);
			seen = busy;
		end
		if (!seen) abort_run("timeout: busy did not rise after start");
	endtask

	task automatic wait_done();
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < DONE_LIMIT && !seen; n++) begin
			@(negedge clk);
			seen = done;
		end
		if (!seen) abort_run("timeout: done did not pulse");
	endtask

	task automatic arm_checks(input logic e_found, input logic [31:0] e_nonce,
			input logic e_hash_chk, input logic [255:0] e_hash);
		exp_found   = e_found;
		exp_nonce   = e_nonce;
		hash_check  = e_hash_chk;
		exp_hash    = e_hash;
		check_armed = 1'b1;
	endtask

	// Step past the done edge so the assertions see it, then disarm
	task automatic finish_search();
		wait_done();
		next_cycle();
		check_armed = 1'b0;
	endtask

	task automatic run_search(input int count, input logic e_found, input logic [31:0] e_nonce,
			input logic e_hash_chk, input logic [255:0] e_hash);
		arm_checks(e_found, e_nonce, e_hash_chk, e_hash);
		pulse_start(count);
		finish_search();
	endtask

	initial begin
		data_en     = 1'b0;
		data_sel    = '0;
		data        = '0;
		start       = 1'b0;
		attempts    = '0;
		check_armed = 1'b0;
		hash_check  = 1'b0;
		idle_check  = 1'b0;
		exp_found   = 1'b0;
		exp_nonce   = '0;
		exp_hash    = '0;
		void'($urandom(76418));

		// Quiet outputs after reset
		wait_reset_release();
		next_cycle();
		idle_check = 1'b1;
		repeat (4) next_cycle();
		idle_check = 1'b0;

		// Three misses, then the genesis nonce hits a target equal to its hash
		load_store(32'h7c2bac1a, GENESIS_HASH);
		run_search(8, 1'b1, 32'h7c2bac1d, 1'b1, GENESIS_HASH);

		// Nonce bytes alone rewritten, single attempt
		write_nonce(32'h7c2bac1d);
		run_search(1, 1'b1, 32'h7c2bac1d, 1'b1, GENESIS_HASH);

		// Nothing is at or below zero, nonce wraps after three misses
		write_target(256'd0);
		write_nonce(32'hfffffffe);
		run_search(3, 1'b0, 32'h00000001, 1'b0, 256'd0);

		// Repeat of the genesis search with writes and a start while busy
		load_store(32'h7c2bac1a, GENESIS_HASH);
		arm_checks(1'b1, 32'h7c2bac1d, 1'b1, GENESIS_HASH);
		pulse_start(8);
		wait_busy();
		next_cycle();
		for (int k = 0; k < 4; k++) begin
			write_byte(76 + k, 8'hff);
		end
		for (int k = 0; k < 32; k++) begin
			write_byte(80 + k, 8'h00);
		end
		data_en = 1'b0;
		pulse_start(1);
		finish_search();

		$display("test passed");
		$finish;
	end

endmodule

/* pow_miner_top.f */
hdl/pow_pkg.sv
hdl/header_store.sv
hdl/sha256_compress.sv
hdl/double_hash_seq.sv
hdl/nonce_search.sv
hdl/pow_miner_top.sv
testbench/tb_clock.sv
testbench/pow_miner_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the miner testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module pow_miner_tb \
	-f pow_miner_top.f \
	-Mdir obj_dir -o pow_miner_sim

sim_out=$(./obj_dir/pow_miner_sim) || true
echo "$sim_out"

if grep -qx "test passed" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
